/* kernel_ctrl_top.f */
rtl/kernel_ctrl_pkg.sv
rtl/kernel_control.sv
rtl/descriptor_decode.sv
rtl/vertex_execute.sv
rtl/vertex_result.sv
rtl/kernel_ctrl_top.sv
tb/kernel_ctrl_properties.sv
tb/kernel_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the kernel control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module kernel_ctrl_tb \
    -f kernel_ctrl_top.f -o kernel_ctrl_sim

output=$(./obj_dir/kernel_ctrl_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* tb/kernel_ctrl_tb.sv */
// Kernel control testbench
// Random jobs from an xorshift generator go through the host handshake.
// A model here predicts the vertex id walk and the result sum of each
// job, with both endian flags, and checks the DUT against it

`timescale 1ns/1ps

module kernel_ctrl_tb;

    localparam int job_count   = 40;
    localparam int ready_limit = 50;
    localparam int done_limit  = 200;

    logic                                       ap_clk;
    logic                                       areset_control;
    logic                                       ap_start;
    logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_0;
    logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_1;
    logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_9;
    logic                                       ap_ready;
    logic                                       ap_done;
    logic                                       ap_idle;
    logic                                       vertex_valid;
    logic [kernel_ctrl_pkg::vertex_id_width-1:0] vertex_id;
    logic [kernel_ctrl_pkg::sum_width-1:0]       result_sum;

    // Generator state and last sum the host should still see
    logic [31:0]                          rng_state;
    logic [kernel_ctrl_pkg::sum_width-1:0] prev_sum;
    int                                   value_errors;
    int                                   timeouts;

    kernel_ctrl_top kernel_ctrl_top_i (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .ap_start       (ap_start),
        .buffer_0       (buffer_0),
        .buffer_1       (buffer_1),
        .buffer_9       (buffer_9),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .vertex_valid   (vertex_valid),
        .vertex_id      (vertex_id),
        .result_sum     (result_sum)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Host byte order of a 64-bit word
    function automatic logic [kernel_ctrl_pkg::buffer_width-1:0] reverse_bytes(
        input logic [kernel_ctrl_pkg::buffer_width-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24], w[39:32], w[47:40], w[55:48], w[63:56]};
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    task automatic check_vertex(input string name,
                                input logic [kernel_ctrl_pkg::vertex_id_width-1:0] expected,
                                input logic [kernel_ctrl_pkg::vertex_id_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    task automatic check_sum(input string name,
                             input logic [kernel_ctrl_pkg::sum_width-1:0] expected,
                             input logic [kernel_ctrl_pkg::sum_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    // ------------------------------------------------------------
    // One job from descriptor to ap_done
    // ------------------------------------------------------------
    task automatic run_job(input int job);
        logic [31:0]                             r;
        logic [31:0]                             base;
        logic [31:0]                             count;
        logic [31:0]                             seen;
        logic [31:0]                             exp_id;
        logic [31:0]                             gap;
        logic [31:0]                             i;
        logic                                    rd_swap;
        logic                                    wr_swap;
        logic                                    got;
        logic [kernel_ctrl_pkg::sum_width-1:0]    sum;
        logic [kernel_ctrl_pkg::buffer_width-1:0] word_0;
        logic [kernel_ctrl_pkg::buffer_width-1:0] word_1;

        r = next_random();
        base = r;
        // Some bases near the top so the walk wraps
        if (job % 7 == 5) begin
            base = 32'hffff_ffc0 | {27'd0, r[4:0]};
        end
        r = next_random();
        count = {26'd0, r[5:0]};
        if (job % 10 == 3) begin
            count = 32'd0;
        end
        rd_swap = r[8];
        wr_swap = r[9];
        // Upper bits are junk the decode must ignore
        word_0 = {next_random(), base};
        word_1 = {next_random(), r[31:16], count[15:0]};

        // Expected sum of zero-extended ids, wrapping at 32 bits
        sum = '0;
        for (i = 32'd0; i < count; i = i + 32'd1) begin
            sum = sum + {32'd0, base + i};
        end
        if (wr_swap) begin
            sum = reverse_bytes(sum);
        end

        @(posedge ap_clk);
        #1;
        buffer_0 = rd_swap ? reverse_bytes(word_0) : word_0;
        buffer_1 = rd_swap ? reverse_bytes(word_1) : word_1;
        r = next_random();
        buffer_9 = {r, r[29:0], wr_swap, rd_swap};
        ap_start = 1'b1;

        // Hold ap_start until ap_ready
        got = 1'b0;
        for (int cycles = 0; cycles < ready_limit && !got; cycles++) begin
            @(negedge ap_clk);
            check_bit("vertex_valid", 1'b0, vertex_valid);
            check_sum("result_sum", prev_sum, result_sum);
            got = (ap_ready === 1'b1);
        end
        if (!got) begin
            $display("Timed out waiting for ap_ready on job %0d", job);
            timeouts++;
            return;
        end
        @(posedge ap_clk);
        #1;
        ap_start = 1'b0;

        // Vertex walk up to ap_done
        got = 1'b0;
        seen = 32'd0;
        exp_id = base;
        for (int cycles = 0; cycles < done_limit && !got; cycles++) begin
            @(negedge ap_clk);
            if (vertex_valid === 1'b1) begin
                if (seen < count) begin
                    check_vertex("vertex_id", exp_id, vertex_id);
                end else begin
                    $display("Job %0d emitted a vertex beyond its count of %0d", job, count);
                    value_errors++;
                end
                // Old sum still visible during the walk
                check_sum("result_sum", prev_sum, result_sum);
                // Job in flight, not idle and not done
                check_bit("ap_idle", 1'b0, ap_idle);
                check_bit("ap_done", 1'b0, ap_done);
                exp_id = exp_id + 32'd1;
                seen = seen + 32'd1;
            end
            got = (ap_done === 1'b1);
        end
        if (!got) begin
            $display("Timed out waiting for ap_done on job %0d", job);
            timeouts++;
            return;
        end
        if (seen != count) begin
            $display("Job %0d produced %0d vertices instead of %0d", job, seen, count);
            value_errors++;
        end
        check_sum("result_sum", sum, result_sum);
        check_bit("ap_idle", 1'b1, ap_idle);
        check_bit("ap_ready", 1'b0, ap_ready);
        prev_sum = sum;

        // Done and idle hold through a short random gap
        r = next_random();
        gap = {30'd0, r[1:0]};
        repeat (gap) begin
            @(negedge ap_clk);
            check_bit("ap_done", 1'b1, ap_done);
            check_bit("ap_idle", 1'b1, ap_idle);
            check_bit("vertex_valid", 1'b0, vertex_valid);
            check_sum("result_sum", sum, result_sum);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        rng_state = 32'hb6b6f992;
        value_errors = 0;
        timeouts = 0;
        prev_sum = '0;
        areset_control = 1'b1;
        ap_start = 1'b0;
        buffer_0 = '0;
        buffer_1 = '0;
        buffer_9 = '0;

        repeat (10) @(posedge ap_clk);
        #1;
        areset_control = 1'b0;

        // Quiet controller until the first ap_start
        repeat (8) begin
            @(negedge ap_clk);
            check_bit("ap_idle", 1'b1, ap_idle);
            check_bit("ap_ready", 1'b0, ap_ready);
            check_bit("ap_done", 1'b0, ap_done);
            check_bit("vertex_valid", 1'b0, vertex_valid);
            check_sum("result_sum", '0, result_sum);
        end

        for (int job = 0; job < job_count && timeouts == 0; job++) begin
            run_job(job);
        end

        $display("Run complete: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : kernel_ctrl_tb

/* tb/kernel_ctrl_properties.sv */
// Kernel control properties
// Concurrent checks on the block-level handshake and the
// descriptor window, bound into every kernel_control instance

`timescale 1ns/1ps

module kernel_ctrl_properties (
    input logic                               ap_clk,
    input logic                               areset_control,
    input logic                               ap_ready,
    input logic                               ap_done,
    input logic                               ap_idle,
    input logic                               descriptor_valid,
    input kernel_ctrl_pkg::ctrl_chain_state_t current_state
);

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------
    ready_single_cycle: assert property (@(posedge ap_clk) disable iff (areset_control)
        ap_ready |=> !ap_ready)
        else $error("ap_ready stayed high for more than one cycle");

    ready_done_exclusive: assert property (@(posedge ap_clk) disable iff (areset_control)
        !(ap_done && ap_ready))
        else $error("ap_done and ap_ready high together");

    idle_while_done: assert property (@(posedge ap_clk) disable iff (areset_control)
        ap_done |-> ap_idle)
        else $error("ap_done high without ap_idle");

    // Outputs trail the state by two register stages
    descriptor_low_in_done: assert property (@(posedge ap_clk) disable iff (areset_control)
        $past(current_state == kernel_ctrl_pkg::ctrl_chain_done, 2) |-> !descriptor_valid)
        else $error("descriptor_valid high in the done state");

endmodule : kernel_ctrl_properties

bind kernel_control kernel_ctrl_properties kernel_ctrl_properties_i (
    .ap_clk           (ap_clk),
    .areset_control   (areset_control),
    .ap_ready         (ap_ready),
    .ap_done          (ap_done),
    .ap_idle          (ap_idle),
    .descriptor_valid (descriptor_valid),
    .current_state    (current_state)
);

/* rtl/kernel_ctrl_top.sv */
// Kernel control top
// Controller, descriptor decode, vertex walk and result accumulation
// for one compute unit behind the block-level host handshake

`timescale 1ns/1ps

module kernel_ctrl_top (
    input  logic                                       ap_clk,
    input  logic                                       areset_control,
    input  logic                                       ap_start,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_0,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_1,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0]    buffer_9,
    output logic                                       ap_ready,
    output logic                                       ap_done,
    output logic                                       ap_idle,
    output logic                                       vertex_valid,
    output logic [kernel_ctrl_pkg::vertex_id_width-1:0] vertex_id,
    output logic [kernel_ctrl_pkg::sum_width-1:0]       result_sum
);

    // Controller to decode and result
    logic                                    descriptor_valid;
    logic                                    endian_read;
    logic                                    endian_write;
    logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_0_q;
    logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_1_q;

    // Decode to execute
    logic                                          launch;
    logic [kernel_ctrl_pkg::vertex_id_width-1:0]    base_index;
    logic [kernel_ctrl_pkg::vertex_count_width-1:0] vertex_count;

    // Execute and result back to the controller
    logic last;
    logic empty_job;
    logic cu_setup;
    logic cu_done;

    kernel_control kernel_control_i (
        .ap_clk           (ap_clk),
        .areset_control   (areset_control),
        .ap_start         (ap_start),
        .cu_setup         (cu_setup),
        .cu_done          (cu_done),
        .buffer_0         (buffer_0),
        .buffer_1         (buffer_1),
        .buffer_9         (buffer_9),
        .ap_ready         (ap_ready),
        .ap_done          (ap_done),
        .ap_idle          (ap_idle),
        .descriptor_valid (descriptor_valid),
        .endian_read      (endian_read),
        .endian_write     (endian_write),
        .buffer_0_q       (buffer_0_q),
        .buffer_1_q       (buffer_1_q),
        // Flags already split out as endian_read and endian_write
        .buffer_9_q       ()
    );

    descriptor_decode descriptor_decode_i (
        .ap_clk           (ap_clk),
        .areset_control   (areset_control),
        .descriptor_valid (descriptor_valid),
        .endian_read      (endian_read),
        .buffer_0_q       (buffer_0_q),
        .buffer_1_q       (buffer_1_q),
        .launch           (launch),
        .base_index       (base_index),
        .vertex_count     (vertex_count)
    );

    vertex_execute vertex_execute_i (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .launch         (launch),
        .base_index     (base_index),
        .vertex_count   (vertex_count),
        .vertex_valid   (vertex_valid),
        .last           (last),
        .empty_job      (empty_job),
        .cu_setup       (cu_setup),
        .vertex_id      (vertex_id)
    );

    vertex_result vertex_result_i (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .endian_write   (endian_write),
        .vertex_valid   (vertex_valid),
        .last           (last),
        .empty_job      (empty_job),
        .vertex_id      (vertex_id),
        .cu_done        (cu_done),
        .result_sum     (result_sum)
    );

endmodule : kernel_ctrl_top

/* rtl/vertex_result.sv */
// Vertex result
// Accumulates the vertex ids of one job. On the last id, or on an
// empty job, stores the sum (byte-reversed when endian write is set),
// pulses cu_done and clears the accumulator for the next job

`timescale 1ns/1ps

module vertex_result (
    input  logic                                       ap_clk,
    input  logic                                       areset_control,
    input  logic                                       endian_write,
    input  logic                                       vertex_valid,
    input  logic                                       last,
    input  logic                                       empty_job,
    input  logic [kernel_ctrl_pkg::vertex_id_width-1:0] vertex_id,
    output logic                                       cu_done,
    output logic [kernel_ctrl_pkg::sum_width-1:0]       result_sum
);

    logic [kernel_ctrl_pkg::sum_width-1:0] accumulator;
    logic [kernel_ctrl_pkg::sum_width-1:0] job_sum;

    // Running total including the id on the bus this cycle
    assign job_sum = accumulator + kernel_ctrl_pkg::sum_width'(vertex_id);

    // ------------------------------------------------------------
    // Accumulate and close
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            accumulator <= '0;
            cu_done     <= 1'b0;
            result_sum  <= '0;
        end else begin
            cu_done <= 1'b0;
            if (empty_job) begin
                // Zero is the same in either byte order
                result_sum  <= '0;
                cu_done     <= 1'b1;
                accumulator <= '0;
            end else if (last) begin
                result_sum  <= endian_write ? kernel_ctrl_pkg::byte_swap(job_sum) : job_sum;
                cu_done     <= 1'b1;
                accumulator <= '0;
            end else if (vertex_valid) begin
                accumulator <= job_sum;
            end
        end
    end

endmodule : vertex_result

/* rtl/vertex_execute.sv */
// Vertex execute
// Walks vertex ids one per cycle from base_index for vertex_count
// cycles after launch. Flags the final id with last, and a job with
// no vertices with a single empty_job pulse in the launch cycle

`timescale 1ns/1ps

module vertex_execute (
    input  logic                                          ap_clk,
    input  logic                                          areset_control,
    input  logic                                          launch,
    input  logic [kernel_ctrl_pkg::vertex_id_width-1:0]    base_index,
    input  logic [kernel_ctrl_pkg::vertex_count_width-1:0] vertex_count,
    output logic                                          vertex_valid,
    output logic                                          last,
    output logic                                          empty_job,
    output logic                                          cu_setup,
    output logic [kernel_ctrl_pkg::vertex_id_width-1:0]    vertex_id
);

    // Vertices still to come after the current one
    logic [kernel_ctrl_pkg::vertex_count_width-1:0] remaining;

    // ------------------------------------------------------------
    // Walk control
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            vertex_valid <= 1'b0;
        end else if (launch && vertex_count != '0) begin
            vertex_valid <= 1'b1;
        end else if (last) begin
            vertex_valid <= 1'b0;
        end
    end

    // Id and counter, only meaningful while vertex_valid
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            vertex_id <= base_index;
            remaining <= vertex_count - 1'b1;
        end else if (vertex_valid) begin
            // Wraps naturally at 32 bits
            vertex_id <= vertex_id + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    assign last = vertex_valid && remaining == '0;

    // Nothing to walk, result side closes the job directly
    assign empty_job = launch && vertex_count == '0;

    assign cu_setup = ~vertex_valid;

endmodule : vertex_execute

/* rtl/descriptor_decode.sv */
// Descriptor decode
// Turns the rising edge of descriptor_valid into a one-cycle launch
// and captures base index and vertex count with it, byte-reversing
// the descriptor words first when endian read is set

`timescale 1ns/1ps

module descriptor_decode (
    input  logic                                          ap_clk,
    input  logic                                          areset_control,
    input  logic                                          descriptor_valid,
    input  logic                                          endian_read,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0]       buffer_0_q,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0]       buffer_1_q,
    output logic                                          launch,
    output logic [kernel_ctrl_pkg::vertex_id_width-1:0]    base_index,
    output logic [kernel_ctrl_pkg::vertex_count_width-1:0] vertex_count
);

    logic                                    descriptor_valid_d;
    logic [kernel_ctrl_pkg::buffer_width-1:0] word_0;
    logic [kernel_ctrl_pkg::buffer_width-1:0] word_1;

    // Host byte order to native
    assign word_0 = endian_read ? kernel_ctrl_pkg::byte_swap(buffer_0_q) : buffer_0_q;
    assign word_1 = endian_read ? kernel_ctrl_pkg::byte_swap(buffer_1_q) : buffer_1_q;

    // ------------------------------------------------------------
    // Edge detect and launch pulse
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            descriptor_valid_d <= 1'b0;
            launch             <= 1'b0;
        end else begin
            descriptor_valid_d <= descriptor_valid;
            launch             <= descriptor_valid & ~descriptor_valid_d;
        end
    end

    // Fields latched on the same edge, held for the whole job
    always_ff @(posedge ap_clk) begin
        if (descriptor_valid & ~descriptor_valid_d) begin
            base_index   <= word_0[kernel_ctrl_pkg::vertex_id_width-1:0];
            vertex_count <= word_1[kernel_ctrl_pkg::vertex_count_width-1:0];
        end
    end

endmodule : descriptor_decode

/* rtl/kernel_control.sv */
// Kernel control
// Block-level ap_ctrl_chain sequencer for one compute unit. Inputs are
// registered once, state outputs pass through two register stages, and
// the descriptor words are registered twice to line up with them.
// Endian flags from buffer_9 are published only in start and busy

`timescale 1ns/1ps

module kernel_control (
    input  logic                                    ap_clk,
    input  logic                                    areset_control,
    input  logic                                    ap_start,
    input  logic                                    cu_setup,
    input  logic                                    cu_done,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_0,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_1,
    input  logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_9,
    output logic                                    ap_ready,
    output logic                                    ap_done,
    output logic                                    ap_idle,
    output logic                                    descriptor_valid,
    output logic                                    endian_read,
    output logic                                    endian_write,
    output logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_0_q,
    output logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_1_q,
    output logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_9_q
);

    // Input stage
    logic ap_start_reg;
    logic cu_setup_reg;
    logic cu_done_reg;

    // First output stage, set from the current state
    logic ap_ready_reg;
    logic ap_done_reg;
    logic ap_idle_reg;
    logic descriptor_valid_reg;
    logic endian_read_reg;
    logic endian_write_reg;

    logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_0_reg;
    logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_1_reg;
    logic [kernel_ctrl_pkg::buffer_width-1:0] buffer_9_reg;

    kernel_ctrl_pkg::ctrl_chain_state_t current_state;
    kernel_ctrl_pkg::ctrl_chain_state_t next_state;

    // ------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            cu_done_reg  <= 1'b0;
            // CU counts as ready for setup out of reset
            cu_setup_reg <= 1'b1;
        end else begin
            ap_start_reg <= ap_start;
            cu_done_reg  <= cu_done;
            cu_setup_reg <= cu_setup;
        end
    end

    // Descriptor words, two stages to match the control outputs
    always_ff @(posedge ap_clk) begin
        buffer_0_reg <= buffer_0;
        buffer_1_reg <= buffer_1;
        buffer_9_reg <= buffer_9;
        buffer_0_q   <= buffer_0_reg;
        buffer_1_q   <= buffer_1_reg;
        buffer_9_q   <= buffer_9_reg;
    end

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= kernel_ctrl_pkg::ctrl_chain_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            kernel_ctrl_pkg::ctrl_chain_reset: next_state = kernel_ctrl_pkg::ctrl_chain_idle;
            kernel_ctrl_pkg::ctrl_chain_idle:  next_state = kernel_ctrl_pkg::ctrl_chain_setup;
            // New job accepted only here or from done
            kernel_ctrl_pkg::ctrl_chain_setup,
            kernel_ctrl_pkg::ctrl_chain_done: begin
                if (ap_start_reg) begin
                    next_state = kernel_ctrl_pkg::ctrl_chain_ready;
                end
            end
            // Hold until the CU has finished its previous walk
            kernel_ctrl_pkg::ctrl_chain_ready: begin
                if (cu_setup_reg) begin
                    next_state = kernel_ctrl_pkg::ctrl_chain_start;
                end
            end
            kernel_ctrl_pkg::ctrl_chain_start: next_state = kernel_ctrl_pkg::ctrl_chain_busy;
            kernel_ctrl_pkg::ctrl_chain_busy: begin
                if (cu_done_reg) begin
                    next_state = kernel_ctrl_pkg::ctrl_chain_done;
                end
            end
            default: next_state = kernel_ctrl_pkg::ctrl_chain_reset;
        endcase
    end

    // ------------------------------------------------------------
    // Output stages
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready_reg         <= 1'b0;
            ap_done_reg          <= 1'b0;
            ap_idle_reg          <= 1'b1;
            descriptor_valid_reg <= 1'b0;
            endian_read_reg      <= 1'b0;
            endian_write_reg     <= 1'b0;
        end else begin
            ap_ready_reg         <= current_state == kernel_ctrl_pkg::ctrl_chain_ready;
            ap_done_reg          <= current_state == kernel_ctrl_pkg::ctrl_chain_done;
            // Idle everywhere outside an active job
            ap_idle_reg          <= current_state inside {kernel_ctrl_pkg::ctrl_chain_reset,
                                                          kernel_ctrl_pkg::ctrl_chain_idle,
                                                          kernel_ctrl_pkg::ctrl_chain_setup,
                                                          kernel_ctrl_pkg::ctrl_chain_done};
            descriptor_valid_reg <= 1'b0;
            endian_read_reg      <= 1'b0;
            endian_write_reg     <= 1'b0;
            if (current_state inside {kernel_ctrl_pkg::ctrl_chain_start,
                                      kernel_ctrl_pkg::ctrl_chain_busy}) begin
                descriptor_valid_reg <= 1'b1;
                endian_read_reg      <= buffer_9_reg[kernel_ctrl_pkg::endian_read_bit];
                endian_write_reg     <= buffer_9_reg[kernel_ctrl_pkg::endian_write_bit];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready         <= 1'b0;
            ap_done          <= 1'b0;
            ap_idle          <= 1'b1;
            descriptor_valid <= 1'b0;
            endian_read      <= 1'b0;
            endian_write     <= 1'b0;
        end else begin
            ap_ready         <= ap_ready_reg;
            ap_done          <= ap_done_reg;
            ap_idle          <= ap_idle_reg;
            descriptor_valid <= descriptor_valid_reg;
            endian_read      <= endian_read_reg;
            endian_write     <= endian_write_reg;
        end
    end

endmodule : kernel_control

/* rtl/kernel_ctrl_pkg.sv */
// Kernel control package
// Shared widths, endian flag positions, the controller state
// encoding and the byte-reversal helper for descriptor and result words

package kernel_ctrl_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int buffer_width       = 64;
    localparam int vertex_id_width    = 32;
    localparam int vertex_count_width = 16;
    localparam int sum_width          = 64;

    // Endian flag positions in buffer_9
    localparam int endian_read_bit  = 0;
    localparam int endian_write_bit = 1;

    // ------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ctrl_chain_reset,
        ctrl_chain_idle,
        ctrl_chain_setup,
        ctrl_chain_ready,
        ctrl_chain_start,
        ctrl_chain_busy,
        ctrl_chain_done
    } ctrl_chain_state_t;

    // Reverse byte order of one 64-bit word
    function automatic logic [buffer_width-1:0] byte_swap(input logic [buffer_width-1:0] word);
        logic [buffer_width-1:0] swapped;
        for (int i = 0; i < buffer_width / 8; i++) begin
            swapped[8*i +: 8] = word[buffer_width-8-8*i +: 8];
        end
        return swapped;
    endfunction

endpackage : kernel_ctrl_pkg
